// File: all.f
hw/attn_pkg.sv
hw/operand_ram.sv
hw/linear_projection.sv
hw/score_matmul.sv
hw/row_exp2.sv
hw/attention_head.sv
tb/attention_head_sva.sv
tb/tb_attention_head.sv

// File: hw/attention_head.sv
/* One head, no V path and no softmax divide; host loads X, Wq, Wk before start.
   Start is ignored while a run is in flight; one row of weights per out_valid */
`timescale 1ns/1ps

module attention_head #(
    parameter int PROJ_SHIFT  = 6,
    parameter int SCORE_SHIFT = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en_a,
    input  attn_pkg::mem_addr_t     wr_addr_a,
    input  attn_pkg::operand_word_u wr_data_a,
    input  logic                    wr_en_b,
    input  attn_pkg::mem_addr_t     wr_addr_b,
    input  attn_pkg::operand_word_u wr_data_b,
    input  logic                    start,
    output logic                    out_valid,
    output attn_pkg::row_idx_t      out_row,
    output attn_pkg::weight_word_t  out_weights,
    output logic                    out_done
);
    import attn_pkg::*;

    // Memory read path
    mem_addr_t     rd_addr;
    operand_word_u rd_data;

    // Projection stream
    logic                     proj_busy;
    logic                     proj_valid;
    logic                     proj_is_key;
    row_idx_t                 proj_row;
    row_idx_t                 proj_col;
    logic signed [ELEM_W-1:0] proj_value;
    logic                     proj_done;

    // Score stream
    logic                    score_valid;
    row_idx_t                score_row;
    row_idx_t                score_col;
    logic signed [ACC_W-1:0] score_value;

    operand_ram u_ram (
        .clk       (clk),
        .reset     (reset),
        .wr_en_a   (wr_en_a),
        .wr_addr_a (wr_addr_a),
        .wr_data_a (wr_data_a),
        .wr_en_b   (wr_en_b),
        .wr_addr_b (wr_addr_b),
        .wr_data_b (wr_data_b),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Busy runs until the last output row
    linear_projection #(
        .PROJ_SHIFT (PROJ_SHIFT)
    ) u_proj (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .done_in     (out_done),
        .busy        (proj_busy),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .proj_valid  (proj_valid),
        .proj_is_key (proj_is_key),
        .proj_row    (proj_row),
        .proj_col    (proj_col),
        .proj_value  (proj_value),
        .proj_done   (proj_done)
    );

    score_matmul u_score (
        .clk         (clk),
        .reset       (reset),
        .proj_valid  (proj_valid),
        .proj_is_key (proj_is_key),
        .proj_row    (proj_row),
        .proj_col    (proj_col),
        .proj_value  (proj_value),
        .proj_done   (proj_done),
        .score_valid (score_valid),
        .score_row   (score_row),
        .score_col   (score_col),
        .score_value (score_value)
    );

    row_exp2 #(
        .SCORE_SHIFT (SCORE_SHIFT)
    ) u_exp (
        .clk         (clk),
        .reset       (reset),
        .score_valid (score_valid),
        .score_row   (score_row),
        .score_col   (score_col),
        .score_value (score_value),
        .out_valid   (out_valid),
        .out_row     (out_row),
        .out_weights (out_weights),
        .out_done    (out_done)
    );

endmodule

// File: hw/attn_pkg.sv
/* Sizes are fixed for one head of four tokens at model width four.
   Operand memory map: X rows at 0..3, Wq rows at 4..7, Wk rows at 8..11 (weights transposed) */
package attn_pkg;

    // Head geometry
    localparam int SEQ_LEN  = 4;
    localparam int D_MODEL  = 4;

    // Element and accumulator widths
    localparam int ELEM_W   = 8;
    localparam int ACC_W    = 18;
    localparam int WEIGHT_W = 8;
    localparam int WORD_W   = D_MODEL * ELEM_W;

    // Operand memory layout
    localparam int MEM_WORDS = 12;
    localparam int W_BASE    = 4;

    typedef logic [1:0] row_idx_t;
    typedef logic [3:0] mem_addr_t;

    // Signed int8 lane, keeps its sign when picked out of a packed array
    typedef logic signed [ELEM_W-1:0] elem_t;

    // One operand word, seen as raw bits or as four int8 lanes
    typedef union packed {
        logic [WORD_W-1:0]       raw;
        elem_t [D_MODEL-1:0]     lane;
    } operand_word_u;

    // Lane j holds the weight for key column j
    typedef logic [SEQ_LEN-1:0][WEIGHT_W-1:0] weight_word_t;

endpackage

// File: hw/linear_projection.sv
/* Fixed schedule: per token one X read, then eight weight rows at two cycles each.
   Start is ignored from acceptance until done_in; elements are saturated to int8 */
`timescale 1ns/1ps

module linear_projection #(
    parameter int PROJ_SHIFT = 6
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic                              done_in,
    output logic                              busy,
    output attn_pkg::mem_addr_t               rd_addr,
    input  attn_pkg::operand_word_u           rd_data,
    output logic                              proj_valid,
    output logic                              proj_is_key,
    output attn_pkg::row_idx_t                proj_row,
    output attn_pkg::row_idx_t                proj_col,
    output logic signed [attn_pkg::ELEM_W-1:0] proj_value,
    output logic                              proj_done
);
    import attn_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_X,
        S_RD_W,
        S_COMP,
        S_DONE,
        S_WAIT
    } state_t;

    localparam logic signed [ACC_W-1:0] SAT_HI = 127;
    localparam logic signed [ACC_W-1:0] SAT_LO = -128;

    state_t state;

    // Current token and weight row, 0..3 Wq then 4..7 Wk
    row_idx_t   tok;
    logic [2:0] w_idx;

    // Latched token row
    operand_word_u x_row;

    logic signed [ACC_W-1:0]  dot;
    logic signed [ACC_W-1:0]  scaled;
    logic signed [ELEM_W-1:0] sat;

    assign busy = (state != S_IDLE);

    // Read address follows the state directly
    always_comb begin
        case (state)
            S_RD_X:         rd_addr = mem_addr_t'(tok);
            S_RD_W, S_COMP: rd_addr = mem_addr_t'(W_BASE + w_idx);
            default:        rd_addr = '0;
        endcase
    end

    // Four-lane product sum, weight row arrives on rd_data in S_COMP
    always_comb begin
        dot = '0;
        for (int l = 0; l < D_MODEL; l++) begin
            dot = dot + x_row.lane[l] * rd_data.lane[l];
        end
    end

    // Rescale then clamp to int8
    assign scaled = dot >>> PROJ_SHIFT;

    always_comb begin
        if (scaled > SAT_HI) begin
            sat = SAT_HI[ELEM_W-1:0];
        end else if (scaled < SAT_LO) begin
            sat = SAT_LO[ELEM_W-1:0];
        end else begin
            sat = scaled[ELEM_W-1:0];
        end
    end

    // Sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            tok        <= '0;
            w_idx      <= '0;
            proj_valid <= 1'b0;
            proj_done  <= 1'b0;
        end else begin
            proj_valid <= 1'b0;
            proj_done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        tok   <= '0;
                        w_idx <= '0;
                        state <= S_RD_X;
                    end
                end
                S_RD_X: state <= S_RD_W;
                S_RD_W: state <= S_COMP;
                S_COMP: begin
                    proj_valid <= 1'b1;
                    w_idx      <= w_idx + 3'd1;
                    if (w_idx == 3'd7) begin
                        tok   <= tok + 2'd1;
                        // Last token goes on to the done strobe
                        state <= (tok == row_idx_t'(SEQ_LEN - 1)) ? S_DONE : S_RD_X;
                    end else begin
                        state <= S_RD_W;
                    end
                end
                S_DONE: begin
                    proj_done <= 1'b1;
                    state     <= S_WAIT;
                end
                // Hold off new starts until the last row leaves the head
                S_WAIT: begin
                    if (done_in) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        // First weight read cycle still shows the X row
        if (state == S_RD_W && w_idx == 3'd0) begin
            x_row <= rd_data;
        end
        if (state == S_COMP) begin
            proj_is_key <= w_idx[2];
            proj_row    <= tok;
            proj_col    <= w_idx[1:0];
            proj_value  <= sat;
        end
    end

endmodule

// File: hw/operand_ram.sv
/* Writes above the last word are dropped; port b wins on a same-address write.
   Read data is registered, one cycle after the address */
`timescale 1ns/1ps

module operand_ram (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en_a,
    input  attn_pkg::mem_addr_t     wr_addr_a,
    input  attn_pkg::operand_word_u wr_data_a,
    input  logic                    wr_en_b,
    input  attn_pkg::mem_addr_t     wr_addr_b,
    input  attn_pkg::operand_word_u wr_data_b,
    input  attn_pkg::mem_addr_t     rd_addr,
    output attn_pkg::operand_word_u rd_data
);
    import attn_pkg::*;

    // Twelve raw words: X, Wq, Wk
    logic [WORD_W-1:0] mem [MEM_WORDS];

    // Address decode for the in-range checks
    logic a_hit;
    logic b_hit;
    logic rd_hit;

    assign a_hit  = wr_en_a && (wr_addr_a < MEM_WORDS);
    assign b_hit  = wr_en_b && (wr_addr_b < MEM_WORDS);
    assign rd_hit = rd_addr < MEM_WORDS;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole array cleared so a rerun never sees old operands
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rd_data.raw <= '0;
        end else begin
            if (a_hit) begin
                mem[wr_addr_a] <= wr_data_a.raw;
            end
            // Later assignment, so b overrides a on collision
            if (b_hit) begin
                mem[wr_addr_b] <= wr_data_b.raw;
            end
            // Unmapped addresses read as zero
            if (rd_hit) begin
                rd_data.raw <= mem[rd_addr];
            end else begin
                rd_data.raw <= '0;
            end
        end
    end

endmodule

// File: hw/row_exp2.sv
/* Weights are 255 >> ((max - s) >> SCORE_SHIFT), unnormalized, zero past a shift of 7.
   Rows must arrive with columns 0..3 in order; output is two cycles after column 3 */
`timescale 1ns/1ps

module row_exp2 #(
    parameter int SCORE_SHIFT = 4
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              score_valid,
    input  attn_pkg::row_idx_t                score_row,
    input  attn_pkg::row_idx_t                score_col,
    input  logic signed [attn_pkg::ACC_W-1:0] score_value,
    output logic                              out_valid,
    output attn_pkg::row_idx_t                out_row,
    output attn_pkg::weight_word_t            out_weights,
    output logic                              out_done
);
    import attn_pkg::*;

    // Collector stage
    logic signed [ACC_W-1:0] col_buf [SEQ_LEN];
    logic                    row_full;
    row_idx_t                full_row;

    // Comparator tree
    logic signed [ACC_W-1:0] max01;
    logic signed [ACC_W-1:0] max23;
    logic signed [ACC_W-1:0] row_max;

    // Max stage
    logic                    s2_valid;
    row_idx_t                s2_row;
    logic signed [ACC_W-1:0] s2_max;
    logic signed [ACC_W-1:0] s2_score [SEQ_LEN];

    // Difference and shift amount per column
    logic signed [ACC_W:0] diff  [SEQ_LEN];
    logic [ACC_W:0]        shamt [SEQ_LEN];

    always_ff @(posedge clk) begin
        if (score_valid) begin
            col_buf[score_col] <= score_value;
        end
        if (score_valid && score_col == row_idx_t'(SEQ_LEN - 1)) begin
            full_row <= score_row;
        end
    end

    // Two-level max over the buffered row
    assign max01   = (col_buf[0] > col_buf[1]) ? col_buf[0] : col_buf[1];
    assign max23   = (col_buf[2] > col_buf[3]) ? col_buf[2] : col_buf[3];
    assign row_max = (max01 > max23) ? max01 : max23;

    always_ff @(posedge clk) begin
        if (reset) begin
            row_full <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            row_full <= score_valid && (score_col == row_idx_t'(SEQ_LEN - 1));
            s2_valid <= row_full;
        end
    end

    // Snapshot frees the collector for the next row
    always_ff @(posedge clk) begin
        if (row_full) begin
            s2_row   <= full_row;
            s2_max   <= row_max;
            s2_score <= col_buf;
        end
    end

    // Diff is never negative, one extra bit covers the full range
    always_comb begin
        for (int j = 0; j < SEQ_LEN; j++) begin
            diff[j]        = s2_max - s2_score[j];
            shamt[j]       = diff[j] >> SCORE_SHIFT;
            out_weights[j] = (shamt[j] <= (WEIGHT_W - 1))
                             ? ({WEIGHT_W{1'b1}} >> shamt[j][2:0])
                             : '0;
        end
    end

    assign out_valid = s2_valid;
    assign out_row   = s2_row;
    // Last row closes the run
    assign out_done  = s2_valid && (s2_row == row_idx_t'(SEQ_LEN - 1));

endmodule

// File: hw/score_matmul.sv
/* Scores run row-major, one per cycle, starting the cycle after proj_done.
   Q and K must be fully written before proj_done; no back-pressure */
`timescale 1ns/1ps

module score_matmul (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               proj_valid,
    input  logic                               proj_is_key,
    input  attn_pkg::row_idx_t                 proj_row,
    input  attn_pkg::row_idx_t                 proj_col,
    input  logic signed [attn_pkg::ELEM_W-1:0] proj_value,
    input  logic                               proj_done,
    output logic                               score_valid,
    output attn_pkg::row_idx_t                 score_row,
    output attn_pkg::row_idx_t                 score_col,
    output logic signed [attn_pkg::ACC_W-1:0]  score_value
);
    import attn_pkg::*;

    localparam int N_SCORES = SEQ_LEN * SEQ_LEN;

    // Q and K register files, [token][head dim]
    elem_t q_mem [SEQ_LEN][D_MODEL];
    elem_t k_mem [SEQ_LEN][D_MODEL];

    // Score walk
    logic       run;
    logic [3:0] cnt;
    row_idx_t   qi;
    row_idx_t   kj;

    logic signed [ACC_W-1:0] dot;

    assign qi = cnt[3:2];
    assign kj = cnt[1:0];

    // Fill from the projection stream
    always_ff @(posedge clk) begin
        if (proj_valid) begin
            if (proj_is_key) begin
                k_mem[proj_row][proj_col] <= proj_value;
            end else begin
                q_mem[proj_row][proj_col] <= proj_value;
            end
        end
    end

    // S[i][j] = Q row i dot K row j, full width
    always_comb begin
        dot = '0;
        for (int d = 0; d < D_MODEL; d++) begin
            dot = dot + q_mem[qi][d] * k_mem[kj][d];
        end
    end

    // Sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            run         <= 1'b0;
            cnt         <= '0;
            score_valid <= 1'b0;
        end else begin
            score_valid <= run;
            if (proj_done) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 4'd1;
                // Stop after the sixteenth score
                if (cnt == 4'(N_SCORES - 1)) begin
                    run <= 1'b0;
                end
            end
        end
    end

    // Score payload
    always_ff @(posedge clk) begin
        if (run) begin
            score_row   <= qi;
            score_col   <= kj;
            score_value <= dot;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator and run; success only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_attention_head \
    -f all.f -o sim_tb \
  && ./obj_dir/sim_tb 2>&1 | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  || { echo "SIMULATION FAILED"; exit 1; }
exit 0

// File: tb/attention_head_sva.sv
/* Port-level protocol checks for the head, sampled on the rising clock edge.
   proj_busy is the projection's internal busy flag, reached through the bind */
`timescale 1ns/1ps

module attention_head_sva (
    input logic               clk,
    input logic               reset,
    input logic               wr_en_a,
    input logic               wr_en_b,
    input logic               proj_busy,
    input logic               out_valid,
    input attn_pkg::row_idx_t out_row,
    input logic               out_done
);

    // Done only marks a valid row
    a_done_with_valid: assert property (@(posedge clk) disable iff (reset)
        out_done |-> out_valid)
        else $error("out_done raised without out_valid");

    // Back-to-back strobes must carry different rows
    a_no_repeat_row: assert property (@(posedge clk) disable iff (reset)
        (out_valid && $past(out_valid)) |-> (out_row != $past(out_row)))
        else $error("same output row strobed in consecutive cycles");

    // Operands stay still while a run is in flight
    a_no_write_busy: assert property (@(posedge clk) disable iff (reset)
        (wr_en_a || wr_en_b) |-> !proj_busy)
        else $error("operand write while projection busy");

    // Outputs quiet right after any reset cycle
    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!out_valid && !out_done))
        else $error("output active in the cycle after reset");

endmodule

// File: tb/tb_attention_head.sv
/* Model assumes the default shifts PROJ_SHIFT 6 and SCORE_SHIFT 4.
   Inputs change on the rising edge and outputs are sampled on the falling edge */
`timescale 1ns/1ps

module tb_attention_head;
    import attn_pkg::*;

    localparam int PROJ_SHIFT  = 6;
    localparam int SCORE_SHIFT = 4;
    localparam int WQ_BASE     = 4;
    localparam int WK_BASE     = 8;
    localparam int ROW_TIMEOUT = 3000;

    logic          clk;
    logic          reset;
    logic          wr_en_a;
    mem_addr_t     wr_addr_a;
    operand_word_u wr_data_a;
    logic          wr_en_b;
    mem_addr_t     wr_addr_b;
    operand_word_u wr_data_b;
    logic          start;
    logic          out_valid;
    row_idx_t      out_row;
    weight_word_t  out_weights;
    logic          out_done;

    // Local copy of the operand memory and the expected rows
    logic [WORD_W-1:0] mem_model [MEM_WORDS];
    weight_word_t      exp_rows [SEQ_LEN];
    logic [31:0]       lcg_state;

    attention_head u_dut (
        .clk         (clk),
        .reset       (reset),
        .wr_en_a     (wr_en_a),
        .wr_addr_a   (wr_addr_a),
        .wr_data_a   (wr_data_a),
        .wr_en_b     (wr_en_b),
        .wr_addr_b   (wr_addr_b),
        .wr_data_b   (wr_data_b),
        .start       (start),
        .out_valid   (out_valid),
        .out_row     (out_row),
        .out_weights (out_weights),
        .out_done    (out_done)
    );

    bind attention_head attention_head_sva u_sva (
        .clk       (clk),
        .reset     (reset),
        .wr_en_a   (wr_en_a),
        .wr_en_b   (wr_en_b),
        .proj_busy (proj_busy),
        .out_valid (out_valid),
        .out_row   (out_row),
        .out_done  (out_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_row(row_idx_t got_row, row_idx_t exp_row,
                             weight_word_t got_w, weight_word_t exp_w);
        if (got_row !== exp_row || got_w !== exp_w) begin
            abort_run($sformatf("Mismatch at %0t: row %0d weights %h, expected row %0d weights %h",
                                $time, got_row, got_w, exp_row, exp_w));
        end
    endtask

    task automatic check_done(logic got, logic exp, string what);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG halves only since the low bits repeat quickly
    function automatic logic [WORD_W-1:0] rand_word();
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = lcg_next();
        r1 = lcg_next();
        return {r0[31:16], r1[31:16]};
    endfunction

    function automatic int lane_of(logic [WORD_W-1:0] w, int l);
        logic signed [ELEM_W-1:0] b;
        b = w[l*ELEM_W +: ELEM_W];
        return int'(b);
    endfunction

    function automatic int sat8(int v);
        if (v > 127) begin
            return 127;
        end
        if (v < -128) begin
            return -128;
        end
        return v;
    endfunction

    // Q, K, scores and base-2 weights from the memory copy
    function automatic void compute_model();
        int q [SEQ_LEN][D_MODEL];
        int k [SEQ_LEN][D_MODEL];
        int s [SEQ_LEN];
        int acc_q;
        int acc_k;
        int m;
        int sh;
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int j = 0; j < D_MODEL; j++) begin
                acc_q = 0;
                acc_k = 0;
                for (int l = 0; l < D_MODEL; l++) begin
                    acc_q += lane_of(mem_model[i], l) * lane_of(mem_model[WQ_BASE + j], l);
                    acc_k += lane_of(mem_model[i], l) * lane_of(mem_model[WK_BASE + j], l);
                end
                q[i][j] = sat8(acc_q >>> PROJ_SHIFT);
                k[i][j] = sat8(acc_k >>> PROJ_SHIFT);
            end
        end
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int j = 0; j < SEQ_LEN; j++) begin
                s[j] = 0;
                for (int dd = 0; dd < D_MODEL; dd++) begin
                    s[j] += q[i][dd] * k[j][dd];
                end
            end
            m = s[0];
            for (int j = 1; j < SEQ_LEN; j++) begin
                if (s[j] > m) begin
                    m = s[j];
                end
            end
            for (int j = 0; j < SEQ_LEN; j++) begin
                sh = (m - s[j]) >>> SCORE_SHIFT;
                exp_rows[i][j] = (sh <= 7) ? 8'(255 >> sh) : 8'd0;
            end
        end
    endfunction

    // One write cycle on both ports then both released
    task automatic write_pair(logic en_a, mem_addr_t addr_a, logic [WORD_W-1:0] data_a,
                              logic en_b, mem_addr_t addr_b, logic [WORD_W-1:0] data_b);
        @(posedge clk);
        wr_en_a       <= en_a;
        wr_addr_a     <= addr_a;
        wr_data_a.raw <= data_a;
        wr_en_b       <= en_b;
        wr_addr_b     <= addr_b;
        wr_data_b.raw <= data_b;
        // Port b applied second so it wins a collision
        if (en_a && int'(addr_a) < MEM_WORDS) begin
            mem_model[addr_a] = data_a;
        end
        if (en_b && int'(addr_b) < MEM_WORDS) begin
            mem_model[addr_b] = data_b;
        end
        @(posedge clk);
        wr_en_a <= 1'b0;
        wr_en_b <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_row();
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid) begin
            if (n == ROW_TIMEOUT) begin
                abort_run("timeout waiting for output row");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Rows first..last in order with done only on the last row of the run
    task automatic collect_rows(int first, int last);
        for (int r = first; r <= last; r++) begin
            wait_row();
            check_row(out_row, row_idx_t'(r), out_weights, exp_rows[r]);
            check_done(out_done, (r == SEQ_LEN - 1), "out_done");
        end
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_done(out_valid, 1'b0, "out_valid while idle");
            check_done(out_done, 1'b0, "out_done while idle");
        end
    endtask

    task automatic run_head();
        compute_model();
        pulse_start();
        collect_rows(0, SEQ_LEN - 1);
    endtask

    task automatic quiet_after_reset();
        expect_quiet(20);
    endtask

    // X picks lane i scaled by 64 so Q and K are plain weight lanes
    task automatic identity_x_run();
        logic [WORD_W-1:0] x;
        logic [WORD_W-1:0] wq;
        logic [WORD_W-1:0] wk;
        for (int i = 0; i < SEQ_LEN; i++) begin
            for (int l = 0; l < D_MODEL; l++) begin
                x[l*ELEM_W +: ELEM_W]  = (l == i) ? 8'd64 : 8'd0;
                wq[l*ELEM_W +: ELEM_W] = 8'(i + 3 * l - 4);
                wk[l*ELEM_W +: ELEM_W] = 8'(5 - 2 * i + l);
            end
            write_pair(1'b1, mem_addr_t'(i), x, 1'b1, mem_addr_t'(WQ_BASE + i), wq);
            write_pair(1'b1, mem_addr_t'(WK_BASE + i), wk, 1'b0, '0, '0);
        end
        run_head();
    endtask

    // Full-range bytes drive saturation and zero weights
    task automatic random_runs();
        repeat (3) begin
            for (int k = 0; k < 6; k++) begin
                write_pair(1'b1, mem_addr_t'(k), rand_word(),
                           1'b1, mem_addr_t'(k + 6), rand_word());
            end
            run_head();
        end
    endtask

    task automatic dual_port_writes();
        write_pair(1'b1, 4'd0, rand_word(), 1'b1, 4'd5, rand_word());
        write_pair(1'b1, 4'd8, rand_word(), 1'b1, 4'd8, rand_word());
        write_pair(1'b1, 4'd13, rand_word(), 1'b0, '0, '0);
        write_pair(1'b0, '0, '0, 1'b1, 4'd13, rand_word());
        run_head();
    endtask

    task automatic start_while_busy();
        compute_model();
        pulse_start();
        // Second start lands mid-projection
        repeat (20) @(posedge clk);
        pulse_start();
        collect_rows(0, 0);
        // Projection has finished here but the run is not done yet
        pulse_start();
        collect_rows(1, SEQ_LEN - 1);
        expect_quiet(300);
    endtask

    task automatic rerun_new_wk();
        for (int k = 0; k < SEQ_LEN; k++) begin
            write_pair(1'b1, mem_addr_t'(WK_BASE + k), rand_word(), 1'b0, '0, '0);
        end
        run_head();
    endtask

    initial begin
        lcg_state     = 32'd96;
        reset         = 1'b1;
        start         = 1'b0;
        wr_en_a       = 1'b0;
        wr_addr_a     = '0;
        wr_data_a.raw = '0;
        wr_en_b       = 1'b0;
        wr_addr_b     = '0;
        wr_data_b.raw = '0;
        // Memory comes out of reset cleared
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        quiet_after_reset();
        identity_x_run();
        random_runs();
        dual_port_writes();
        start_while_busy();
        rerun_new_wk();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
